//--- common/fmul_defines.svh
`ifndef FMUL_DEFINES_SVH
`define FMUL_DEFINES_SVH

// binary32 field layout.
`define FMUL_WORD_W   32
`define FMUL_EXP_W    8
`define FMUL_MAN_W    23
`define FMUL_SIG_W    24 // fraction plus hidden one.
`define FMUL_PROD_W   48
`define FMUL_ESUM_W   10 // signed exponent sum.
`define FMUL_BIAS     127

`define FMUL_REG_W    5
`define FMUL_FLAGS_W  5

`define FMUL_QNAN     32'h7fc00000

// fflags bit positions, dz (bit 3) is never raised.
`define FMUL_NV       4
`define FMUL_OF       2
`define FMUL_UF       1
`define FMUL_NX       0

`endif

//--- common/fmul_pkg.sv
package fmul_pkg;

    // command opcode.
    typedef enum logic {
        op_mul  = 1'b0,
        op_macc = 1'b1
    } fmul_op_e;

    // operand class, subnormals count as zero.
    typedef enum logic [1:0] {
        cls_zero   = 2'd0,
        cls_normal = 2'd1,
        cls_inf    = 2'd2,
        cls_nan    = 2'd3
    } fmul_class_e;

endpackage

//--- fmul/fmul_mantissa.sv
`timescale 1ns/1ps
`include "fmul_defines.svh"

module fmul_mantissa (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            u_valid,
    output logic                            u_ready,
    input  fmul_pkg::fmul_op_e              u_op,
    input  logic                            u_sign,
    input  logic signed [`FMUL_ESUM_W-1:0]  u_exp_sum,
    input  logic [`FMUL_SIG_W-1:0]          u_man_a,
    input  logic [`FMUL_SIG_W-1:0]          u_man_b,
    input  logic                            u_special,
    input  logic [`FMUL_WORD_W-1:0]         u_special_value,
    input  logic [`FMUL_FLAGS_W-1:0]        u_special_flags,
    input  logic [`FMUL_WORD_W-1:0]         u_c,
    input  fmul_pkg::fmul_class_e           u_c_class,
    input  logic [`FMUL_REG_W-1:0]          u_dest,
    output logic                            m_valid,
    input  logic                            m_ready,
    output fmul_pkg::fmul_op_e              m_op,
    output logic                            m_sign,
    output logic signed [`FMUL_ESUM_W-1:0]  m_exp_sum,
    output logic [`FMUL_PROD_W-1:0]         m_product,
    output logic                            m_special,
    output logic [`FMUL_WORD_W-1:0]         m_special_value,
    output logic [`FMUL_FLAGS_W-1:0]        m_special_flags,
    output logic [`FMUL_WORD_W-1:0]         m_c,
    output fmul_pkg::fmul_class_e           m_c_class,
    output logic [`FMUL_REG_W-1:0]          m_dest
);

    localparam int DW = 2 + `FMUL_ESUM_W + `FMUL_PROD_W + 1 + 2 * `FMUL_WORD_W
                        + `FMUL_FLAGS_W + 2 + `FMUL_REG_W;

    logic [`FMUL_PROD_W-1:0] product;
    logic [DW-1:0]           in_data, out_data;
    logic                    op_bit;
    logic [1:0]              c_class_bits;

    assign product = u_man_a * u_man_b; // 24x24, full width.

    assign in_data = {u_op, u_sign, u_exp_sum, product, u_special, u_special_value,
                      u_special_flags, u_c, u_c_class, u_dest};

    stream_stage #(.WIDTH(DW)) stage_inst (
        .clk, .arst_n,
        .in_valid(u_valid), .in_ready(u_ready), .in_data(in_data),
        .out_valid(m_valid), .out_ready(m_ready), .out_data(out_data)
    );

    assign {op_bit, m_sign, m_exp_sum, m_product, m_special, m_special_value,
            m_special_flags, m_c, c_class_bits, m_dest} = out_data;
    assign m_op      = fmul_pkg::fmul_op_e'(op_bit);
    assign m_c_class = fmul_pkg::fmul_class_e'(c_class_bits);

endmodule

//--- fmul/fmul_normalize.sv
`timescale 1ns/1ps
`include "fmul_defines.svh"

module fmul_normalize (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            m_valid,
    output logic                            m_ready,
    input  fmul_pkg::fmul_op_e              m_op,
    input  logic                            m_sign,
    input  logic signed [`FMUL_ESUM_W-1:0]  m_exp_sum,
    input  logic [`FMUL_PROD_W-1:0]         m_product,
    input  logic                            m_special,
    input  logic [`FMUL_WORD_W-1:0]         m_special_value,
    input  logic [`FMUL_FLAGS_W-1:0]        m_special_flags,
    input  logic [`FMUL_WORD_W-1:0]         m_c,
    input  fmul_pkg::fmul_class_e           m_c_class,
    input  logic [`FMUL_REG_W-1:0]          m_dest,
    output logic                            res_valid,
    input  logic                            res_ready,
    output logic [`FMUL_WORD_W-1:0]         res_value,
    output logic [`FMUL_FLAGS_W-1:0]        res_flags,
    output logic [`FMUL_REG_W-1:0]          res_dest,
    output logic                            macc_valid,
    input  logic                            macc_ready,
    output logic [`FMUL_WORD_W-1:0]         macc_product,
    output logic [`FMUL_FLAGS_W-1:0]        macc_flags,
    output logic [`FMUL_WORD_W-1:0]         macc_c,
    output fmul_pkg::fmul_class_e           macc_c_class,
    output logic [`FMUL_REG_W-1:0]          macc_dest
);

    localparam int EW      = `FMUL_EXP_W;
    localparam int MW      = `FMUL_MAN_W;
    localparam int SW      = `FMUL_SIG_W;
    localparam int P       = `FMUL_PROD_W;
    localparam int EXP_INF = (1 << EW) - 1;
    localparam int RES_W   = `FMUL_WORD_W + `FMUL_FLAGS_W + `FMUL_REG_W;
    localparam int MACC_W  = 2 * `FMUL_WORD_W + `FMUL_FLAGS_W + 2 + `FMUL_REG_W;

    logic [MW-1:0]                   frac_pre;
    logic                            guard, sticky, round_up;
    logic [SW:0]                     sig_rnd;
    logic signed [`FMUL_ESUM_W-1:0]  exp_norm, exp_fin;
    logic [`FMUL_WORD_W-1:0]         value;
    logic [`FMUL_FLAGS_W-1:0]        flags;
    logic                            is_mul;
    logic                            res_in_valid, res_in_ready;
    logic                            macc_in_valid, macc_in_ready;
    logic [RES_W-1:0]                res_out_data;
    logic [MACC_W-1:0]               macc_out_data;
    logic [1:0]                      c_class_bits;

    always_comb begin
        if (m_product[P-1]) begin
            frac_pre = m_product[P-2 -: MW]; // product in [2,4).
            guard    = m_product[P-2-MW];
            sticky   = |m_product[P-3-MW:0];
            exp_norm = m_exp_sum + 1;
        end else begin
            frac_pre = m_product[P-3 -: MW];
            guard    = m_product[P-3-MW];
            sticky   = |m_product[P-4-MW:0];
            exp_norm = m_exp_sum;
        end
        round_up = guard & (sticky | frac_pre[0]);
        sig_rnd  = {2'b01, frac_pre} + {{SW{1'b0}}, round_up};
        // a carry out leaves the fraction all zero, so sig_rnd[MW-1:0] is still right.
        exp_fin  = sig_rnd[SW] ? exp_norm + 1 : exp_norm;

        flags = '0;
        if (m_special) begin
            value = m_special_value;
            flags = m_special_flags;
        end else if (exp_fin >= EXP_INF) begin
            value = {m_sign, {EW{1'b1}}, {MW{1'b0}}};
            flags[`FMUL_OF] = 1'b1;
            flags[`FMUL_NX] = 1'b1;
        end else if (exp_fin < 1) begin
            value = {m_sign, {(EW+MW){1'b0}}}; // flush to zero.
            flags[`FMUL_UF] = 1'b1;
            flags[`FMUL_NX] = 1'b1;
        end else begin
            value = {m_sign, exp_fin[EW-1:0], sig_rnd[MW-1:0]};
            flags[`FMUL_NX] = guard | sticky;
        end
    end

    assign is_mul        = (m_op == fmul_pkg::op_mul);
    assign res_in_valid  = m_valid & is_mul;
    assign macc_in_valid = m_valid & ~is_mul;
    assign m_ready       = is_mul ? res_in_ready : macc_in_ready;

    stream_stage #(.WIDTH(RES_W)) res_stage_inst (
        .clk, .arst_n,
        .in_valid(res_in_valid), .in_ready(res_in_ready), .in_data({value, flags, m_dest}),
        .out_valid(res_valid), .out_ready(res_ready), .out_data(res_out_data)
    );

    stream_stage #(.WIDTH(MACC_W)) macc_stage_inst (
        .clk, .arst_n,
        .in_valid(macc_in_valid), .in_ready(macc_in_ready),
        .in_data({value, flags, m_c, m_c_class, m_dest}),
        .out_valid(macc_valid), .out_ready(macc_ready), .out_data(macc_out_data)
    );

    assign {res_value, res_flags, res_dest} = res_out_data;
    assign {macc_product, macc_flags, macc_c, c_class_bits, macc_dest} = macc_out_data;
    assign macc_c_class = fmul_pkg::fmul_class_e'(c_class_bits);

    // a waiting item must not switch slices.
    route_held_while_stalled: assert property (
        @(posedge clk) disable iff (!arst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_op)
    );

endmodule

//--- fmul/fmul_unit.sv
`timescale 1ns/1ps
`include "fmul_defines.svh"

module fmul_unit (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  fmul_pkg::fmul_op_e       cmd_op,
    input  logic [`FMUL_WORD_W-1:0]  cmd_a,
    input  logic [`FMUL_WORD_W-1:0]  cmd_b,
    input  logic [`FMUL_WORD_W-1:0]  cmd_c,
    input  logic [`FMUL_REG_W-1:0]   cmd_dest,
    output logic                     res_valid,
    input  logic                     res_ready,
    output logic [`FMUL_WORD_W-1:0]  res_value,
    output logic [`FMUL_FLAGS_W-1:0] res_flags,
    output logic [`FMUL_REG_W-1:0]   res_dest,
    output logic                     macc_valid,
    input  logic                     macc_ready,
    output logic [`FMUL_WORD_W-1:0]  macc_product,
    output logic [`FMUL_FLAGS_W-1:0] macc_flags,
    output logic [`FMUL_WORD_W-1:0]  macc_c,
    output fmul_pkg::fmul_class_e    macc_c_class,
    output logic [`FMUL_REG_W-1:0]   macc_dest
);

    logic                           u_valid, u_ready, u_sign, u_special;
    fmul_pkg::fmul_op_e             u_op;
    logic signed [`FMUL_ESUM_W-1:0] u_exp_sum;
    logic [`FMUL_SIG_W-1:0]         u_man_a, u_man_b;
    logic [`FMUL_WORD_W-1:0]        u_special_value, u_c;
    logic [`FMUL_FLAGS_W-1:0]       u_special_flags;
    fmul_pkg::fmul_class_e          u_c_class;
    logic [`FMUL_REG_W-1:0]         u_dest;

    logic                           m_valid, m_ready, m_sign, m_special;
    fmul_pkg::fmul_op_e             m_op;
    logic signed [`FMUL_ESUM_W-1:0] m_exp_sum;
    logic [`FMUL_PROD_W-1:0]        m_product;
    logic [`FMUL_WORD_W-1:0]        m_special_value, m_c;
    logic [`FMUL_FLAGS_W-1:0]       m_special_flags;
    fmul_pkg::fmul_class_e          m_c_class;
    logic [`FMUL_REG_W-1:0]         m_dest;

    fmul_unpack unpack_inst (
        .clk, .arst_n,
        .cmd_valid, .cmd_ready, .cmd_op, .cmd_a, .cmd_b, .cmd_c, .cmd_dest,
        .u_valid, .u_ready, .u_op, .u_sign, .u_exp_sum, .u_man_a, .u_man_b,
        .u_special, .u_special_value, .u_special_flags, .u_c, .u_c_class, .u_dest
    );

    fmul_mantissa mantissa_inst (
        .clk, .arst_n,
        .u_valid, .u_ready, .u_op, .u_sign, .u_exp_sum, .u_man_a, .u_man_b,
        .u_special, .u_special_value, .u_special_flags, .u_c, .u_c_class, .u_dest,
        .m_valid, .m_ready, .m_op, .m_sign, .m_exp_sum, .m_product,
        .m_special, .m_special_value, .m_special_flags, .m_c, .m_c_class, .m_dest
    );

    fmul_normalize normalize_inst (
        .clk, .arst_n,
        .m_valid, .m_ready, .m_op, .m_sign, .m_exp_sum, .m_product,
        .m_special, .m_special_value, .m_special_flags, .m_c, .m_c_class, .m_dest,
        .res_valid, .res_ready, .res_value, .res_flags, .res_dest,
        .macc_valid, .macc_ready, .macc_product, .macc_flags, .macc_c,
        .macc_c_class, .macc_dest
    );

endmodule

//--- fmul/fmul_unpack.sv
`timescale 1ns/1ps
`include "fmul_defines.svh"

module fmul_unpack (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            cmd_valid,
    output logic                            cmd_ready,
    input  fmul_pkg::fmul_op_e              cmd_op,
    input  logic [`FMUL_WORD_W-1:0]         cmd_a,
    input  logic [`FMUL_WORD_W-1:0]         cmd_b,
    input  logic [`FMUL_WORD_W-1:0]         cmd_c,
    input  logic [`FMUL_REG_W-1:0]          cmd_dest,
    output logic                            u_valid,
    input  logic                            u_ready,
    output fmul_pkg::fmul_op_e              u_op,
    output logic                            u_sign,
    output logic signed [`FMUL_ESUM_W-1:0]  u_exp_sum,
    output logic [`FMUL_SIG_W-1:0]          u_man_a,
    output logic [`FMUL_SIG_W-1:0]          u_man_b,
    output logic                            u_special,
    output logic [`FMUL_WORD_W-1:0]         u_special_value,
    output logic [`FMUL_FLAGS_W-1:0]        u_special_flags,
    output logic [`FMUL_WORD_W-1:0]         u_c,
    output fmul_pkg::fmul_class_e           u_c_class,
    output logic [`FMUL_REG_W-1:0]          u_dest
);

    localparam int EW = `FMUL_EXP_W;
    localparam int MW = `FMUL_MAN_W;
    localparam int DW = 2 + `FMUL_ESUM_W + 2 * `FMUL_SIG_W + 1 + 2 * `FMUL_WORD_W
                        + `FMUL_FLAGS_W + 2 + `FMUL_REG_W;
    localparam logic signed [`FMUL_ESUM_W-1:0] BIAS = `FMUL_BIAS;

    function automatic fmul_pkg::fmul_class_e classify(input logic [`FMUL_WORD_W-1:0] x);
        logic [EW-1:0] e;
        logic [MW-1:0] f;
        e = x[EW+MW-1:MW];
        f = x[MW-1:0];
        if (e == '0) begin
            return fmul_pkg::cls_zero; // subnormals flush here.
        end else if (e == {EW{1'b1}}) begin
            return (f == '0) ? fmul_pkg::cls_inf : fmul_pkg::cls_nan;
        end
        return fmul_pkg::cls_normal;
    endfunction

    fmul_pkg::fmul_class_e    cls_a, cls_b;
    logic                     sign;
    logic                     snan;
    logic                     special;
    logic [`FMUL_WORD_W-1:0]  value;
    logic [`FMUL_FLAGS_W-1:0] flags;
    logic [`FMUL_ESUM_W-1:0]  exp_sum;
    logic [DW-1:0]            in_data, out_data;
    logic                     op_bit;
    logic [1:0]               c_class_bits;

    assign cls_a   = classify(cmd_a);
    assign cls_b   = classify(cmd_b);
    assign sign    = cmd_a[`FMUL_WORD_W-1] ^ cmd_b[`FMUL_WORD_W-1];
    assign exp_sum = $signed({{(`FMUL_ESUM_W-EW){1'b0}}, cmd_a[EW+MW-1:MW]})
                   + $signed({{(`FMUL_ESUM_W-EW){1'b0}}, cmd_b[EW+MW-1:MW]}) - BIAS;
    assign snan    = (cls_a == fmul_pkg::cls_nan && !cmd_a[MW-1])
                   | (cls_b == fmul_pkg::cls_nan && !cmd_b[MW-1]);
    assign special = (cls_a != fmul_pkg::cls_normal) | (cls_b != fmul_pkg::cls_normal);

    always_comb begin
        flags = '0;
        if (cls_a == fmul_pkg::cls_nan || cls_b == fmul_pkg::cls_nan) begin
            value = `FMUL_QNAN;
            flags[`FMUL_NV] = snan;
        end else if ((cls_a == fmul_pkg::cls_inf && cls_b == fmul_pkg::cls_zero) ||
                     (cls_a == fmul_pkg::cls_zero && cls_b == fmul_pkg::cls_inf)) begin
            value = `FMUL_QNAN; // 0 x inf.
            flags[`FMUL_NV] = 1'b1;
        end else if (cls_a == fmul_pkg::cls_inf || cls_b == fmul_pkg::cls_inf) begin
            value = {sign, {EW{1'b1}}, {MW{1'b0}}};
        end else begin
            value = {sign, {(EW+MW){1'b0}}};
        end
    end

    assign in_data = {cmd_op, sign, exp_sum, 1'b1, cmd_a[MW-1:0], 1'b1, cmd_b[MW-1:0],
                      special, value, flags, cmd_c, classify(cmd_c), cmd_dest};

    stream_stage #(.WIDTH(DW)) stage_inst (
        .clk, .arst_n,
        .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(in_data),
        .out_valid(u_valid), .out_ready(u_ready), .out_data(out_data)
    );

    assign {op_bit, u_sign, u_exp_sum, u_man_a, u_man_b, u_special, u_special_value,
            u_special_flags, u_c, c_class_bits, u_dest} = out_data;
    assign u_op      = fmul_pkg::fmul_op_e'(op_bit);
    assign u_c_class = fmul_pkg::fmul_class_e'(c_class_bits);

endmodule

//--- logic/stream_stage.sv
`timescale 1ns/1ps

module stream_stage #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    logic             main_valid;
    logic [WIDTH-1:0] main_data;
    logic             skid_valid;
    logic [WIDTH-1:0] skid_data;
    logic             in_fire;
    logic             main_free;

    assign in_ready  = ~skid_valid; // straight from a flop.
    assign in_fire   = in_valid & in_ready;
    assign main_free = out_ready | ~main_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            main_valid <= skid_valid | in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1; // output stalled, park it.
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (in_fire && !main_free) begin
            skid_data <= in_data;
        end
    end

    assign out_valid = main_valid;
    assign out_data  = main_data;

    out_data_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_fmul_unit

# the binary exits non-zero on $fatal, the log decides the outcome.
./obj_dir/Vtb_fmul_unit > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- src.f
+incdir+common
common/fmul_pkg.sv
logic/stream_stage.sv
fmul/fmul_unpack.sv
fmul/fmul_mantissa.sv
fmul/fmul_normalize.sv
fmul/fmul_unit.sv
tests/tb_fmul_unit.sv

//--- tests/tb_fmul_unit.sv
`timescale 1ns/1ps
`include "fmul_defines.svh"

module tb_fmul_unit;

    localparam int num_cmds = 33;
    localparam logic [`FMUL_FLAGS_W-1:0] fl_nv = 5'(1 << `FMUL_NV);
    localparam logic [`FMUL_FLAGS_W-1:0] fl_of = 5'(1 << `FMUL_OF);
    localparam logic [`FMUL_FLAGS_W-1:0] fl_uf = 5'(1 << `FMUL_UF);
    localparam logic [`FMUL_FLAGS_W-1:0] fl_nx = 5'(1 << `FMUL_NX);

    logic                           clk = 1'b0;
    logic                           arst_n = 1'b0;
    logic                           cmd_valid = 1'b0;
    logic                           cmd_ready;
    fmul_pkg::fmul_op_e             cmd_op = fmul_pkg::op_mul;
    logic [`FMUL_WORD_W-1:0]        cmd_a = '0;
    logic [`FMUL_WORD_W-1:0]        cmd_b = '0;
    logic [`FMUL_WORD_W-1:0]        cmd_c = '0;
    logic [`FMUL_REG_W-1:0]         cmd_dest = '0;
    logic                           res_valid, macc_valid;
    logic                           res_ready = 1'b1;
    logic                           macc_ready = 1'b1;
    logic [`FMUL_WORD_W-1:0]        res_value, macc_product, macc_c;
    logic [`FMUL_FLAGS_W-1:0]       res_flags, macc_flags;
    logic [`FMUL_REG_W-1:0]         res_dest, macc_dest;
    fmul_pkg::fmul_class_e          macc_c_class;

    integer      seed = 32'hf573;
    logic [31:0] rnd;
    logic        bp_on = 1'b0;
    int          cycle_cnt = 0;
    int          cmd_cycle, res_cycle;
    logic [73:0] res_got[$];  // {cycle, value, flags, dest}.
    logic [75:0] macc_got[$]; // {product, flags, c, class, dest}.

    fmul_unit UUT (
        .clk, .arst_n,
        .cmd_valid, .cmd_ready, .cmd_op, .cmd_a, .cmd_b, .cmd_c, .cmd_dest,
        .res_valid, .res_ready, .res_value, .res_flags, .res_dest,
        .macc_valid, .macc_ready, .macc_product, .macc_flags, .macc_c,
        .macc_c_class, .macc_dest
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    always @(posedge clk) begin
        #1;
        if (bp_on) begin
            rnd = $random(seed);
            res_ready  = rnd[0];
            macc_ready = rnd[1];
        end else begin
            res_ready  = 1'b1;
            macc_ready = 1'b1;
        end
    end

    // valid and ready are both settled at the falling edge.
    always @(negedge clk) begin
        if (res_valid && res_ready) begin
            res_got.push_back({32'(cycle_cnt), res_value, res_flags, res_dest});
        end
        if (macc_valid && macc_ready) begin
            macc_got.push_back({macc_product, macc_flags, macc_c, macc_c_class, macc_dest});
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input logic [`FMUL_WORD_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s value %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flags(input logic [`FMUL_FLAGS_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s flags %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_class(input fmul_pkg::fmul_class_e got, exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s class %s, expected %s",
                                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_dest(input logic [`FMUL_REG_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s dest %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    // sign and magnitude of an integer below 2**24 as binary32.
    function automatic logic [31:0] int_to_float(input logic sign, input int unsigned mag);
        int          msb;
        logic [31:0] shifted;
        msb = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        shifted = mag << (23 - msb);
        return {sign, 8'(127 + msb), shifted[22:0]};
    endfunction

    task automatic send_cmd(input fmul_pkg::fmul_op_e op, input logic [31:0] a, b, c,
                            input logic [`FMUL_REG_W-1:0] dest);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_a     = a;
        cmd_b     = b;
        cmd_c     = c;
        cmd_dest  = dest;
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        cmd_cycle = cycle_cnt;
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    // waits for the counts, then a few idle cycles to catch stray items.
    task automatic wait_results(input int n_res, input int n_macc);
        int waited;
        waited = 0;
        while ((res_got.size() < n_res || macc_got.size() < n_macc) && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        repeat (6) @(posedge clk);
        #1;
        if (res_got.size() != n_res || macc_got.size() != n_macc) begin
            abort_run($sformatf("got %0d results and %0d macc items, expected %0d and %0d",
                                res_got.size(), macc_got.size(), n_res, n_macc));
        end
    endtask

    task automatic expect_res(input logic [31:0] value, input logic [4:0] flags,
                              input logic [4:0] dest, input string what);
        logic [73:0] item;
        item = res_got.pop_front();
        res_cycle = int'(item[73:42]);
        check_value(item[41:10], value, what);
        check_flags(item[9:5], flags, what);
        check_dest(item[4:0], dest, what);
    endtask

    task automatic expect_macc(input logic [31:0] value, input logic [4:0] flags,
                               input logic [31:0] c, input fmul_pkg::fmul_class_e cls,
                               input logic [4:0] dest, input string what);
        logic [75:0] item;
        item = macc_got.pop_front();
        check_value(item[75:44], value, what);
        check_flags(item[43:39], flags, what);
        check_value(item[38:7], c, {what, " c operand"});
        check_class(fmul_pkg::fmul_class_e'(item[6:5]), cls, what);
        check_dest(item[4:0], dest, what);
    endtask

    task automatic test_plain_mul;
        send_cmd(fmul_pkg::op_mul, 32'h40400000, 32'h40200000, 32'h0, 5'd3);
        wait_results(1, 0);
        expect_res(32'h40f00000, 5'b0, 5'd3, "3.0 x 2.5");
        if (res_cycle - cmd_cycle != 3) begin
            abort_run($sformatf("result came %0d cycles after the command instead of 3",
                                res_cycle - cmd_cycle));
        end
    endtask

    task automatic test_rounding;
        send_cmd(fmul_pkg::op_mul, 32'h3f800001, 32'h3f800001, 32'h0, 5'd4);
        send_cmd(fmul_pkg::op_mul, 32'h3f800001, 32'h3fc00000, 32'h0, 5'd5);
        send_cmd(fmul_pkg::op_mul, 32'h3f800003, 32'h3fc00000, 32'h0, 5'd6);
        wait_results(3, 0);
        expect_res(32'h3f800002, fl_nx, 5'd4, "(1+2^-23)^2");
        expect_res(32'h3fc00002, fl_nx, 5'd5, "tie with odd lsb"); // rounds up.
        expect_res(32'h3fc00004, fl_nx, 5'd6, "tie with even lsb"); // rounds down.
    endtask

    task automatic test_special;
        send_cmd(fmul_pkg::op_mul, 32'h00000000, 32'h7f800000, 32'h0, 5'd11);
        send_cmd(fmul_pkg::op_mul, 32'h7fc00000, 32'h3f800000, 32'h0, 5'd12);
        send_cmd(fmul_pkg::op_mul, 32'h7f800000, 32'hc0000000, 32'h0, 5'd13);
        send_cmd(fmul_pkg::op_mul, 32'h71800000, 32'h71800000, 32'h0, 5'd14);
        send_cmd(fmul_pkg::op_mul, 32'h8d800000, 32'h0d800000, 32'h0, 5'd15);
        wait_results(5, 0);
        expect_res(32'h7fc00000, fl_nv, 5'd11, "0 x inf");
        expect_res(32'h7fc00000, 5'b0, 5'd12, "quiet nan x 1.0");
        expect_res(32'hff800000, 5'b0, 5'd13, "inf x -2");
        expect_res(32'h7f800000, fl_of | fl_nx, 5'd14, "2^100 x 2^100");
        expect_res(32'h80000000, fl_uf | fl_nx, 5'd15, "-2^-100 x 2^-100");
    endtask

    task automatic test_macc;
        send_cmd(fmul_pkg::op_macc, 32'h40400000, 32'h40200000, 32'hc1200000, 5'd7);
        send_cmd(fmul_pkg::op_macc, 32'h40000000, 32'h40400000, 32'h7f800000, 5'd8);
        send_cmd(fmul_pkg::op_mul, 32'h40000000, 32'h40000000, 32'h3f800000, 5'd9);
        send_cmd(fmul_pkg::op_macc, 32'h3f800000, 32'h3f000000, 32'h00000001, 5'd10);
        wait_results(1, 3);
        expect_macc(32'h40f00000, 5'b0, 32'hc1200000, fmul_pkg::cls_normal, 5'd7, "macc 3x2.5");
        expect_macc(32'h40c00000, 5'b0, 32'h7f800000, fmul_pkg::cls_inf, 5'd8, "macc 2x3");
        expect_res(32'h40800000, 5'b0, 5'd9, "mul 2x2 among macc");
        expect_macc(32'h3f000000, 5'b0, 32'h00000001, fmul_pkg::cls_zero, 5'd10, "macc 1x0.5");
    endtask

    task automatic test_burst;
        logic [31:0]           c_vals[5] = '{32'h3f800000, 32'h7f800000, 32'h7fc00001,
                                             32'h00000001, 32'h80000000};
        fmul_pkg::fmul_class_e c_cls[5] = '{fmul_pkg::cls_normal, fmul_pkg::cls_inf,
                                            fmul_pkg::cls_nan, fmul_pkg::cls_zero,
                                            fmul_pkg::cls_zero};
        fmul_pkg::fmul_op_e    ops[20];
        logic [31:0]           a_v[20], b_v[20], prod_v[20];
        int                    c_idx[20];
        int unsigned           ia, ib;
        int                    n_mul;
        logic [31:0]           r;
        n_mul = 0;
        for (int i = 0; i < 20; i++) begin
            ia = ($random(seed) & 32'h7ff) + 1;
            ib = ($random(seed) & 32'h7ff) + 1;
            r = $random(seed);
            ops[i] = fmul_pkg::fmul_op_e'(r[0]);
            a_v[i] = int_to_float(r[1], ia);
            b_v[i] = int_to_float(r[2], ib);
            prod_v[i] = int_to_float(r[1] ^ r[2], ia * ib); // exact, below 2^22.
            c_idx[i] = int'(r[5:3]) % 5;
            n_mul += (ops[i] == fmul_pkg::op_mul) ? 1 : 0;
        end
        bp_on = 1'b1;
        for (int i = 0; i < 20; i++) begin
            send_cmd(ops[i], a_v[i], b_v[i], c_vals[c_idx[i]], 5'(i));
        end
        wait_results(n_mul, 20 - n_mul);
        bp_on = 1'b0;
        for (int i = 0; i < 20; i++) begin
            if (ops[i] == fmul_pkg::op_mul) begin
                expect_res(prod_v[i], 5'b0, 5'(i), $sformatf("burst item %0d", i));
            end else begin
                expect_macc(prod_v[i], 5'b0, c_vals[c_idx[i]], c_cls[c_idx[i]], 5'(i),
                            $sformatf("burst item %0d", i));
            end
        end
    endtask

    initial begin
        repeat (num_cmds * 10 + 200) @(posedge clk);
        abort_run("simulation timed out before the tests finished");
    end

    initial begin
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        if (!cmd_ready || res_valid || macc_valid) begin
            abort_run("stream handshake signals have wrong values after reset");
        end
        test_plain_mul();
        test_rounding();
        test_special();
        test_macc();
        test_burst();
        $display("** PASS **");
        $finish;
    end

endmodule
